/* hdl/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath width
`define XLEN 32

// Host bus address width, byte addressed
`define AXI_ADDR_W 5

// Operand registers, host writable
`define REG_INSTR  5'h00
`define REG_RS1    5'h04
`define REG_RS2    5'h08
`define REG_PC     5'h0C

// Result registers, read only
`define REG_RESULT 5'h10
`define REG_STATUS 5'h14
`define REG_NEXTPC 5'h18

`endif

/* hdl/rvIsaPkg.sv */
`include "rv_config.svh"

package rvIsaPkg;

  // Architectural data word
  typedef logic [`XLEN-1:0] word_t;

  // Instruction fields
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;
  typedef logic [4:0] shamt_t;  // Shift amount, low bits of operand B

  // Major opcodes handled by the execute unit
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,  // Register-register
    OPC_OPIMM  = 7'b0010011,  // Register-immediate
    OPC_BRANCH = 7'b1100011   // Conditional branch
  } opcode_e;

endpackage

/* hdl/axiRegPkg.sv */
`include "rv_config.svh"

package axiRegPkg;

  typedef logic [`AXI_ADDR_W-1:0] axiAddr_t;

  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  typedef enum logic {
    WR_IDLE,  // Waiting for address and data together
    WR_RESP   // Holding write response
  } wrState_e;

  typedef enum logic {
    RD_IDLE,  // Address accepted here
    RD_DATA   // Holding read data
  } rdState_e;

endpackage

/* hdl/fa32.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module fa32 (
  input  rvIsaPkg::word_t A,
  input  rvIsaPkg::word_t B,
  input  logic            Cin,
  output rvIsaPkg::word_t S,
  output logic            Cout
);

  rvIsaPkg::word_t  gen;
  rvIsaPkg::word_t  prop;
  logic [`XLEN:0]   carry;  // carry[i] enters bit i

  assign carry[0] = Cin;

  for (genvar i = 0; i < `XLEN; i++) begin : gBit
    assign gen[i]       = A[i] & B[i];
    assign prop[i]      = A[i] ^ B[i];
    assign S[i]         = prop[i] ^ carry[i];
    assign carry[i + 1] = gen[i] | (prop[i] & carry[i]);
  end

  assign Cout = carry[`XLEN];

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
  input  rvIsaPkg::word_t   srcA,
  input  rvIsaPkg::word_t   srcB,
  input  rvIsaPkg::funct3_t funct3,
  input  logic              altOp,
  input  logic              branchMode,
  output rvIsaPkg::word_t   aluResult,
  output logic              branchFlag
);

  rvIsaPkg::word_t  diff;
  rvIsaPkg::shamt_t shamt;
  logic             carryOut;
  logic             overflow;
  logic             signedLess;
  logic             unsignedLess;
  logic             equal;

  // A - B as A + ~B + 1
  fa32 subtractor (
    .A   (srcA),
    .B   (~srcB),
    .Cin (1'b1),
    .S   (diff),
    .Cout(carryOut)
  );

  // Overflow when operand signs differ and the result sign flips from A
  assign overflow     = (srcA[31] ^ srcB[31]) & (diff[31] ^ srcA[31]);
  assign signedLess   = diff[31] ^ overflow;
  assign unsignedLess = ~carryOut;  // Borrow out
  assign equal        = (diff == '0);
  assign shamt        = srcB[4:0];

  always_comb begin
    aluResult  = '0;
    branchFlag = 1'b0;

    if (branchMode) begin
      case (funct3)
        3'b000:  branchFlag = equal;          // BEQ
        3'b001:  branchFlag = ~equal;         // BNE
        3'b100:  branchFlag = signedLess;     // BLT
        3'b101:  branchFlag = ~signedLess;    // BGE, taken on equal too
        3'b110:  branchFlag = unsignedLess;   // BLTU
        3'b111:  branchFlag = ~unsignedLess;  // BGEU
        default: branchFlag = 1'b0;
      endcase
    end else begin
      case (funct3)
        3'b000:  aluResult = altOp ? diff : srcA + srcB;  // SUB / ADD
        3'b001:  aluResult = srcA << shamt;               // SLL
        3'b010:  aluResult = {31'b0, signedLess};         // SLT
        3'b011:  aluResult = {31'b0, unsignedLess};       // SLTU
        3'b100:  aluResult = srcA ^ srcB;                 // XOR
        3'b101: begin
          if (altOp)
            aluResult = $signed(srcA) >>> shamt;  // SRA
          else
            aluResult = srcA >> shamt;            // SRL
        end
        3'b110:  aluResult = srcA | srcB;  // OR
        default: aluResult = srcA & srcB;  // AND
      endcase
    end
  end

endmodule

/* hdl/execUnit.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module execUnit (
  input  rvIsaPkg::word_t instr,
  input  rvIsaPkg::word_t rs1,
  input  rvIsaPkg::word_t rs2,
  input  rvIsaPkg::word_t pc,
  output rvIsaPkg::word_t result,
  output rvIsaPkg::word_t nextPc,
  output logic            branchTaken,
  output logic            illegal
);

  rvIsaPkg::opcode_e opcode;
  rvIsaPkg::funct3_t funct3;
  rvIsaPkg::funct7_t funct7;
  rvIsaPkg::word_t   immI;
  rvIsaPkg::word_t   immB;
  rvIsaPkg::word_t   srcB;
  rvIsaPkg::word_t   aluResult;
  rvIsaPkg::word_t   pcOffset;
  logic              isOp;
  logic              isOpImm;
  logic              isBranch;
  logic              altOp;
  logic              branchFlag;

  // Field extraction
  assign opcode = rvIsaPkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign isOp     = (opcode == rvIsaPkg::OPC_OP);
  assign isOpImm  = (opcode == rvIsaPkg::OPC_OPIMM);
  assign isBranch = (opcode == rvIsaPkg::OPC_BRANCH);
  assign illegal  = ~(isOp | isOpImm | isBranch);

  // Sign-extended immediates
  assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign immB = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                 instr[11:8], 1'b0};

  assign srcB = isOpImm ? immI : rs2;

  // Only shifts look at bit 30 in the immediate form
  always_comb begin
    if (isOp || (isOpImm && funct3 == 3'b101))
      altOp = funct7[5];
    else
      altOp = 1'b0;
  end

  alu aluInst (
    .srcA      (rs1),
    .srcB      (srcB),
    .funct3    (funct3),
    .altOp     (altOp),
    .branchMode(isBranch),
    .aluResult (aluResult),
    .branchFlag(branchFlag)
  );

  assign branchTaken = isBranch & branchFlag;
  assign result      = illegal ? '0 : aluResult;

  // Next PC is target when taken, else fall through
  assign pcOffset = branchTaken ? immB : `XLEN'd4;

  fa32 pcAdder (
    .A   (pc),
    .B   (pcOffset),
    .Cin (1'b0),
    .S   (nextPc),
    .Cout()
  );

endmodule

/* hdl/axiLiteRegs.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module axiLiteRegs (
  input  logic                 clk,
  input  logic                 rst,
  // Write address and data
  input  axiRegPkg::axiAddr_t  awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  rvIsaPkg::word_t      wdata,
  input  logic [`XLEN/8-1:0]   wstrb,
  input  logic                 wvalid,
  output logic                 wready,
  // Write response
  output axiRegPkg::resp_t     bresp,
  output logic                 bvalid,
  input  logic                 bready,
  // Read address and data
  input  axiRegPkg::axiAddr_t  araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output rvIsaPkg::word_t      rdata,
  output axiRegPkg::resp_t     rresp,
  output logic                 rvalid,
  input  logic                 rready,
  // Execute unit side
  input  rvIsaPkg::word_t      result,
  input  rvIsaPkg::word_t      nextPc,
  input  logic                 branchTaken,
  input  logic                 illegal,
  output rvIsaPkg::word_t      instr,
  output rvIsaPkg::word_t      rs1,
  output rvIsaPkg::word_t      rs2,
  output rvIsaPkg::word_t      pc
);

  axiRegPkg::wrState_e wrState;
  axiRegPkg::rdState_e rdState;
  rvIsaPkg::word_t     status;
  rvIsaPkg::word_t     rdWord;
  logic                wrAccept;
  logic                wrHit;
  logic                rdAccept;
  logic                rdHit;

  // Address and data accepted in the same cycle
  assign wrAccept = (wrState == axiRegPkg::WR_IDLE) & awvalid & wvalid;
  assign awready  = wrAccept;
  assign wready   = wrAccept;
  assign rdAccept = arvalid & arready;

  assign status = {{(`XLEN-2){1'b0}}, illegal, branchTaken};

  // Only aligned operand offsets are writable
  always_comb begin
    case (awaddr)
      `REG_INSTR, `REG_RS1, `REG_RS2, `REG_PC: wrHit = 1'b1;
      default:                                 wrHit = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrState <= axiRegPkg::WR_IDLE;
      bvalid  <= 1'b0;
      instr   <= '0;
      rs1     <= '0;
      rs2     <= '0;
      pc      <= '0;
    end else begin
      case (wrState)
        axiRegPkg::WR_IDLE: begin
          if (wrAccept) begin
            bvalid  <= 1'b1;
            wrState <= axiRegPkg::WR_RESP;
            case (awaddr)
              `REG_INSTR: instr <= wdata;
              `REG_RS1:   rs1   <= wdata;
              `REG_RS2:   rs2   <= wdata;
              `REG_PC:    pc    <= wdata;
              default:    ;  // Dropped, answered with SLVERR
            endcase
          end
        end
        axiRegPkg::WR_RESP: begin
          if (bready) begin
            bvalid  <= 1'b0;
            wrState <= axiRegPkg::WR_IDLE;
          end
        end
        default: wrState <= axiRegPkg::WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wrAccept)
      bresp <= wrHit ? axiRegPkg::RESP_OKAY : axiRegPkg::RESP_SLVERR;
  end

  // Read data mux
  always_comb begin
    rdHit = 1'b1;
    case (araddr)
      `REG_INSTR:  rdWord = instr;
      `REG_RS1:    rdWord = rs1;
      `REG_RS2:    rdWord = rs2;
      `REG_PC:     rdWord = pc;
      `REG_RESULT: rdWord = result;
      `REG_STATUS: rdWord = status;
      `REG_NEXTPC: rdWord = nextPc;
      default: begin
        rdWord = '0;
        rdHit  = 1'b0;
      end
    endcase
  end

  // arready comes up one cycle after reset and after each completed read
  always_ff @(posedge clk) begin
    if (rst) begin
      rdState <= axiRegPkg::RD_IDLE;
      rvalid  <= 1'b0;
      arready <= 1'b0;
    end else begin
      case (rdState)
        axiRegPkg::RD_IDLE: begin
          if (rdAccept) begin
            rvalid  <= 1'b1;
            arready <= 1'b0;
            rdState <= axiRegPkg::RD_DATA;
          end else begin
            arready <= 1'b1;
          end
        end
        axiRegPkg::RD_DATA: begin
          if (rready) begin
            rvalid  <= 1'b0;
            arready <= 1'b1;
            rdState <= axiRegPkg::RD_IDLE;
          end
        end
        default: rdState <= axiRegPkg::RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rdAccept) begin
      rdata <= rdWord;
      rresp <= rdHit ? axiRegPkg::RESP_OKAY : axiRegPkg::RESP_SLVERR;
    end
  end

endmodule

/* hdl/aluAxiTop.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module aluAxiTop (
  input  logic                clk,
  input  logic                rst,
  input  axiRegPkg::axiAddr_t awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  rvIsaPkg::word_t     wdata,
  input  logic [`XLEN/8-1:0]  wstrb,
  input  logic                wvalid,
  output logic                wready,
  output axiRegPkg::resp_t    bresp,
  output logic                bvalid,
  input  logic                bready,
  input  axiRegPkg::axiAddr_t araddr,
  input  logic                arvalid,
  output logic                arready,
  output rvIsaPkg::word_t     rdata,
  output axiRegPkg::resp_t    rresp,
  output logic                rvalid,
  input  logic                rready
);

  rvIsaPkg::word_t instr;
  rvIsaPkg::word_t rs1;
  rvIsaPkg::word_t rs2;
  rvIsaPkg::word_t pc;
  rvIsaPkg::word_t result;
  rvIsaPkg::word_t nextPc;
  logic            branchTaken;
  logic            illegal;

  axiLiteRegs regs (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .result(result), .nextPc(nextPc), .branchTaken(branchTaken), .illegal(illegal),
    .instr(instr), .rs1(rs1), .rs2(rs2), .pc(pc)
  );

  // Purely combinational over the registered operands
  execUnit exec (
    .instr(instr), .rs1(rs1), .rs2(rs2), .pc(pc),
    .result(result), .nextPc(nextPc), .branchTaken(branchTaken), .illegal(illegal)
  );

endmodule

/* bench/tb_assertions.sv */
`timescale 1ns/1ps

module axiHandshakeAssertions (
  input logic            clk,
  input logic            rst,
  input logic            arvalid,
  input logic            arready,
  input logic            rvalid,
  input logic            rready,
  input rvIsaPkg::word_t rdata,
  input logic            bvalid,
  input logic            bready
);

  int assertFails = 0;  // Summed into the final verdict

  bHold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
    else begin
      $error("bvalid dropped before bready");
      assertFails++;
    end

  rHold: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
    else begin
      $error("rvalid dropped before rready");
      assertFails++;
    end

  rStable: assert property (@(posedge clk) disable iff (rst)
                            rvalid && !rready |=> $stable(rdata))
    else begin
      $error("rdata changed while rvalid waited");
      assertFails++;
    end

  // Read data one cycle after the AR handshake
  rLatency: assert property (@(posedge clk) disable iff (rst)
                             arvalid && arready |=> $rose(rvalid))
    else begin
      $error("rvalid did not rise one cycle after the address handshake");
      assertFails++;
    end

endmodule

bind axiLiteRegs axiHandshakeAssertions hsAssert (
  .clk(clk), .rst(rst),
  .arvalid(arvalid), .arready(arready),
  .rvalid(rvalid), .rready(rready), .rdata(rdata),
  .bvalid(bvalid), .bready(bready)
);

/* bench/tbChecker.sv */
`timescale 1ns/1ps

module tbChecker (
  input logic             clk,
  input logic             rst,
  input logic             bvalid,
  input logic             bready,
  input axiRegPkg::resp_t bresp,
  input logic             rvalid,
  input logic             rready,
  input rvIsaPkg::word_t  rdata,
  input axiRegPkg::resp_t rresp
);

  // Expectations in issue order, one per transfer
  string            rdName[$];
  rvIsaPkg::word_t  rdData[$];
  axiRegPkg::resp_t rdResp[$];
  string            wrName[$];
  axiRegPkg::resp_t wrResp[$];
  int               passCount = 0;
  int               errorCount = 0;

  task automatic expectRead(input string name, input rvIsaPkg::word_t data,
                            input axiRegPkg::resp_t resp);
    rdName.push_back(name);
    rdData.push_back(data);
    rdResp.push_back(resp);
  endtask

  task automatic expectWrite(input string name, input axiRegPkg::resp_t resp);
    wrName.push_back(name);
    wrResp.push_back(resp);
  endtask

  always @(posedge clk) begin : watchRead
    string            name;
    rvIsaPkg::word_t  expData;
    axiRegPkg::resp_t expResp;
    if (!rst && rvalid && rready) begin
      if (rdName.size() == 0) begin
        $display("Read data arrived with no test waiting for it");
        errorCount++;
      end else begin
        name    = rdName.pop_front();
        expData = rdData.pop_front();
        expResp = rdResp.pop_front();
        if (rdata !== expData || rresp !== expResp) begin
          $display("[ERROR] %s expected 0x%08h resp %0d actual 0x%08h resp %0d",
                   name, expData, expResp, rdata, rresp);
          errorCount++;
        end else begin
          $display("PASS %s", name);
          passCount++;
        end
      end
    end
  end

  always @(posedge clk) begin : watchWrite
    string            name;
    axiRegPkg::resp_t expResp;
    if (!rst && bvalid && bready) begin
      if (wrName.size() == 0) begin
        $display("Write response arrived with no test waiting for it");
        errorCount++;
      end else begin
        name    = wrName.pop_front();
        expResp = wrResp.pop_front();
        if (bresp !== expResp) begin
          $display("[ERROR] %s expected resp %0d actual resp %0d",
                   (name == "") ? "operand write" : name, expResp, bresp);
          errorCount++;
        end else if (name != "") begin
          $display("PASS %s", name);  // Operand writes pass silently
          passCount++;
        end
      end
    end
  end

endmodule

/* bench/tbTop.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module tbTop;

  localparam int TIMEOUT = 64;  // Cycles allowed per handshake

  logic                clk = 1'b0;
  logic                rst = 1'b1;
  axiRegPkg::axiAddr_t awaddr = '0;
  logic                awvalid = 1'b0;
  logic                awready;
  rvIsaPkg::word_t     wdata = '0;
  logic [3:0]          wstrb = 4'hF;  // Ignored by the slave
  logic                wvalid = 1'b0;
  logic                wready;
  axiRegPkg::resp_t    bresp;
  logic                bvalid;
  logic                bready = 1'b0;
  axiRegPkg::axiAddr_t araddr = '0;
  logic                arvalid = 1'b0;
  logic                arready;
  rvIsaPkg::word_t     rdata;
  axiRegPkg::resp_t    rresp;
  logic                rvalid;
  logic                rready = 1'b0;
  int                  timeouts = 0;
  rvIsaPkg::word_t     lastResult;  // Expected RESULT of the last case

  // OP table, alt selects SUB and SRA
  rvIsaPkg::funct3_t opF3[10]  = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  logic              opAlt[10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
  string opName[10] = '{"ADD", "SUB", "SLL", "SLT", "SLTU", "XOR", "SRL", "SRA", "OR", "AND"};
  rvIsaPkg::word_t   edgeA[3] = '{32'h8000_0000, 32'h7FFF_FFFF, 32'hFFFF_FFFF};
  rvIsaPkg::word_t   edgeB[3] = '{32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};

  // Branch conditions against equal, signed-crossing and unsigned-crossing pairs
  rvIsaPkg::funct3_t brF3[6]   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  string             brName[6] = '{"BEQ", "BNE", "BLT", "BGE", "BLTU", "BGEU"};
  rvIsaPkg::word_t   brA[4] = '{32'h1234_5678, 32'hFFFF_FFFF, 32'h0000_0001, 32'h8000_0000};
  rvIsaPkg::word_t   brB[4] = '{32'h1234_5678, 32'h0000_0001, 32'hFFFF_FFFF, 32'h7FFF_FFFF};

  always #2 clk = ~clk;

  aluAxiTop UUT (.*);

  tbChecker chk (.*);

  function automatic void refExec(input rvIsaPkg::word_t instr, input rvIsaPkg::word_t rs1,
                                  input rvIsaPkg::word_t rs2, input rvIsaPkg::word_t pc,
                                  output rvIsaPkg::word_t result,
                                  output rvIsaPkg::word_t status,
                                  output rvIsaPkg::word_t nextPc);
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [4:0]      sh;
    logic            alt;
    logic            taken;
    logic            bad;
    rvIsaPkg::word_t opB;
    rvIsaPkg::word_t immB;
    opc    = instr[6:0];
    f3     = instr[14:12];
    immB   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    opB    = (opc == rvIsaPkg::OPC_OPIMM) ? {{20{instr[31]}}, instr[31:20]} : rs2;
    sh     = opB[4:0];
    alt    = instr[30] & ((opc == rvIsaPkg::OPC_OP) | (f3 == 3'd5));  // ADDI never subtracts
    result = '0;
    taken  = 1'b0;
    bad    = 1'b0;
    if (opc == rvIsaPkg::OPC_OP || opc == rvIsaPkg::OPC_OPIMM) begin
      case (f3)
        3'd0: result = alt ? rs1 - opB : rs1 + opB;
        3'd1: result = rs1 << sh;
        3'd2: result = {31'b0, $signed(rs1) < $signed(opB)};
        3'd3: result = {31'b0, rs1 < opB};
        3'd4: result = rs1 ^ opB;
        3'd5: begin
          if (alt)
            result = $signed(rs1) >>> sh;
          else
            result = rs1 >> sh;
        end
        3'd6: result = rs1 | opB;
        default: result = rs1 & opB;
      endcase
    end else if (opc == rvIsaPkg::OPC_BRANCH) begin
      case (f3)
        3'd0: taken = (rs1 == rs2);
        3'd1: taken = (rs1 != rs2);
        3'd4: taken = ($signed(rs1) < $signed(rs2));
        3'd5: taken = ($signed(rs1) >= $signed(rs2));  // Equal operands branch
        3'd6: taken = (rs1 < rs2);
        3'd7: taken = (rs1 >= rs2);
        default: taken = 1'b0;
      endcase
    end else begin
      bad = 1'b1;
    end
    status = {30'b0, bad, taken};
    nextPc = pc + (taken ? immB : 32'd4);
  endfunction

  function automatic rvIsaPkg::word_t rType(input logic alt, input rvIsaPkg::funct3_t f3);
    return {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, 5'd3, rvIsaPkg::OPC_OP};
  endfunction

  function automatic rvIsaPkg::word_t iType(input logic [11:0] imm, input rvIsaPkg::funct3_t f3);
    return {imm, 5'd1, f3, 5'd3, rvIsaPkg::OPC_OPIMM};
  endfunction

  function automatic rvIsaPkg::word_t bType(input logic [12:0] off, input rvIsaPkg::funct3_t f3);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], rvIsaPkg::OPC_BRANCH};
  endfunction

  task automatic noteTimeout(input string what);
    $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
    timeouts++;
  endtask

  task automatic axiWrite(input axiRegPkg::axiAddr_t addr, input rvIsaPkg::word_t data,
                          input axiRegPkg::resp_t expResp, input string name);
    int   n;
    int   stall;
    logic done;
    stall = $urandom_range(5);
    chk.expectWrite(name, expResp);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    n    = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      @(posedge clk);
      n++;
      done = awready & wready;
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (!done) begin
      noteTimeout("write address and data acceptance");
    end else begin
      n    = 0;
      done = 1'b0;
      while (!done && n < TIMEOUT) begin
        @(posedge clk);
        n++;
        done = bvalid;
      end
      if (!done) begin
        noteTimeout("write response");
      end else begin
        repeat (stall) @(posedge clk);  // Back-pressure on B
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
      end
    end
  endtask

  task automatic axiRead(input string name, input axiRegPkg::axiAddr_t addr,
                         input rvIsaPkg::word_t expData, input axiRegPkg::resp_t expResp);
    int   n;
    int   stall;
    logic done;
    stall = $urandom_range(5);
    chk.expectRead(name, expData, expResp);
    araddr  <= addr;
    arvalid <= 1'b1;
    n    = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      @(posedge clk);
      n++;
      done = arready;
    end
    arvalid <= 1'b0;
    if (!done) begin
      noteTimeout("read address acceptance");
    end else begin
      n    = 0;
      done = 1'b0;
      while (!done && n < TIMEOUT) begin
        @(posedge clk);
        n++;
        done = rvalid;
      end
      if (!done) begin
        noteTimeout("read data");
      end else begin
        repeat (stall) @(posedge clk);  // Back-pressure on R
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
      end
    end
  endtask

  task automatic runCase(input string name, input rvIsaPkg::word_t instr,
                         input rvIsaPkg::word_t rs1, input rvIsaPkg::word_t rs2,
                         input rvIsaPkg::word_t pc, input logic checkData, input logic checkFlow);
    rvIsaPkg::word_t expResult;
    rvIsaPkg::word_t expStatus;
    rvIsaPkg::word_t expNextPc;
    refExec(instr, rs1, rs2, pc, expResult, expStatus, expNextPc);
    lastResult = expResult;
    axiWrite(`REG_INSTR, instr, axiRegPkg::RESP_OKAY, "");
    axiWrite(`REG_RS1, rs1, axiRegPkg::RESP_OKAY, "");
    axiWrite(`REG_RS2, rs2, axiRegPkg::RESP_OKAY, "");
    axiWrite(`REG_PC, pc, axiRegPkg::RESP_OKAY, "");
    if (checkData)
      axiRead({name, " RESULT"}, `REG_RESULT, expResult, axiRegPkg::RESP_OKAY);
    if (checkFlow) begin
      axiRead({name, " STATUS"}, `REG_STATUS, expStatus, axiRegPkg::RESP_OKAY);
      axiRead({name, " NEXTPC"}, `REG_NEXTPC, expNextPc, axiRegPkg::RESP_OKAY);
    end
  endtask

  initial begin
    logic [11:0]     imm;
    logic [12:0]     off;
    rvIsaPkg::word_t a;
    rvIsaPkg::word_t b;
    int              total;
    void'($urandom(32'h8fa2fdc9));
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // All-zero instruction after reset is illegal
    axiRead("reset RESULT", `REG_RESULT, 32'd0, axiRegPkg::RESP_OKAY);
    axiRead("reset STATUS", `REG_STATUS, 32'd2, axiRegPkg::RESP_OKAY);
    axiRead("reset NEXTPC", `REG_NEXTPC, 32'd4, axiRegPkg::RESP_OKAY);

    for (int i = 0; i < 10; i++) begin
      for (int k = 0; k < 4; k++) begin
        a = (k < 3) ? edgeA[k] : $urandom;
        b = (k < 3) ? edgeB[k] : $urandom;
        runCase($sformatf("%s set %0d", opName[i], k), rType(opAlt[i], opF3[i]), a, b,
                $urandom & 32'hFFFF_FFFC, 1'b1, 1'b0);
      end
    end

    for (int f = 0; f < 8; f++) begin
      imm = 12'($urandom);
      runCase($sformatf("OPIMM funct3 %0d", f), iType(imm, 3'(f)), $urandom, $urandom,
              32'h40, 1'b1, 1'b0);
    end
    imm = 12'h400 | 12'($urandom_range(1023));  // Bit 30 set on ADDI
    runCase("ADDI bit30", iType(imm, 3'd0), $urandom, 32'h0, 32'h40, 1'b1, 1'b0);
    imm = {7'b0100000, 5'($urandom_range(31, 1))};  // Nonzero shift tells SRAI from SRLI
    runCase("SRAI", iType(imm, 3'd5), 32'hF0F0_1234, 32'h0, 32'h40, 1'b1, 1'b0);
    runCase("SRLI", iType({7'b0, imm[4:0]}, 3'd5), 32'hF0F0_1234, 32'h0, 32'h40, 1'b1, 1'b0);

    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < 4; k++) begin
        off = 13'($urandom) & 13'h1FFE;
        runCase($sformatf("%s pair %0d", brName[i], k), bType(off, brF3[i]), brA[k], brB[k],
                $urandom & 32'hFFFF_FFFC, 1'b0, 1'b1);
      end
    end

    runCase("illegal opcode", {25'($urandom), 7'b0000011}, $urandom, $urandom,
            32'h1000, 1'b1, 1'b1);

    // Unmapped offset 0x1C
    runCase("ADD before bad write", rType(1'b0, 3'd0), $urandom, $urandom, 32'h80, 1'b1, 1'b0);
    axiRead("bad address read", 5'h1C, 32'd0, axiRegPkg::RESP_SLVERR);
    axiWrite(5'h1C, $urandom, axiRegPkg::RESP_SLVERR, "bad address write");
    axiRead("RESULT after bad write", `REG_RESULT, lastResult, axiRegPkg::RESP_OKAY);
    axiRead("PC after bad write", `REG_PC, 32'h80, axiRegPkg::RESP_OKAY);

    for (int k = 0; k < 3; k++) begin
      a = $urandom;
      b = $urandom;
      runCase($sformatf("readback %0d", k), rType(1'b0, 3'd4), a, b, 32'h100, 1'b1, 1'b0);
      axiRead($sformatf("readback %0d INSTR", k), `REG_INSTR, rType(1'b0, 3'd4),
              axiRegPkg::RESP_OKAY);
      axiRead($sformatf("readback %0d RS1", k), `REG_RS1, a, axiRegPkg::RESP_OKAY);
      axiRead($sformatf("readback %0d RS2", k), `REG_RS2, b, axiRegPkg::RESP_OKAY);
      axiRead($sformatf("readback %0d PC", k), `REG_PC, 32'h100, axiRegPkg::RESP_OKAY);
    end

    repeat (4) @(posedge clk);  // Let the checker settle the last compare
    total = chk.errorCount + timeouts + UUT.regs.hsAssert.assertFails;
    $display("Tests passed: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
             chk.passCount, chk.errorCount, timeouts, UUT.regs.hsAssert.assertFails);
    if (total == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+hdl
hdl/rvIsaPkg.sv
hdl/axiRegPkg.sv
hdl/fa32.sv
hdl/alu.sv
hdl/execUnit.sv
hdl/axiLiteRegs.sv
hdl/aluAxiTop.sv
bench/tb_assertions.sv
bench/tbChecker.sv
bench/tbTop.sv

/* Makefile */
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f project.f --top-module tbTop -o simv
	./obj_dir/simv +verilator+error+limit+100 | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module tbTop

clean:
	rm -rf obj_dir $(LOG)
